/* common/id_config.svh */
`ifndef ID_CONFIG_SVH
`define ID_CONFIG_SVH

// inst[31:22]
`define SLTI_OPCODE      10'h008
`define SLTUI_OPCODE     10'h009
`define ADDIW_OPCODE     10'h00a
`define ANDI_OPCODE      10'h00d
`define ORI_OPCODE       10'h00e
`define XORI_OPCODE      10'h00f
`define LDB_OPCODE       10'h0a0
`define LDH_OPCODE       10'h0a1
`define LDW_OPCODE       10'h0a2
`define STB_OPCODE       10'h0a4
`define STH_OPCODE       10'h0a5
`define STW_OPCODE       10'h0a6
`define LDBU_OPCODE      10'h0a8
`define LDHU_OPCODE      10'h0a9

// inst[31:15]
`define ADDW_OPCODE      17'h00020
`define SUBW_OPCODE      17'h00022
`define SLT_OPCODE       17'h00024
`define SLTU_OPCODE      17'h00025
`define NOR_OPCODE       17'h00028
`define AND_OPCODE       17'h00029
`define OR_OPCODE        17'h0002a
`define XOR_OPCODE       17'h0002b
`define SLLW_OPCODE      17'h0002e
`define SRLW_OPCODE      17'h0002f
`define SRAW_OPCODE      17'h00030
`define MULW_OPCODE      17'h00038
`define MULHW_OPCODE     17'h00039
`define MULHWU_OPCODE    17'h0003a
`define DIVW_OPCODE      17'h00040
`define MODW_OPCODE      17'h00041
`define DIVWU_OPCODE     17'h00042
`define MODWU_OPCODE     17'h00043
`define BREAK_OPCODE     17'h00054
`define SYSCALL_OPCODE   17'h00056
`define SLLIW_OPCODE     17'h00081
`define SRLIW_OPCODE     17'h00089
`define SRAIW_OPCODE     17'h00091

`define LU12I_OPCODE     7'h0a
`define PCADDU12I_OPCODE 7'h0e
`define CSR_OPCODE       8'h04
`define ERTN_OPCODE      22'h1920e

// inst[31:26]
`define JIRL_OPCODE      6'h13
`define B_OPCODE         6'h14
`define BL_OPCODE        6'h15
`define BEQ_OPCODE       6'h16
`define BNE_OPCODE       6'h17
`define BLT_OPCODE       6'h18
`define BGE_OPCODE       6'h19
`define BLTU_OPCODE      6'h1a
`define BGEU_OPCODE      6'h1b

`define ALU_SEL_NOP         3'd0
`define ALU_SEL_LOGIC       3'd1
`define ALU_SEL_SHIFT       3'd2
`define ALU_SEL_ARITHMETIC  3'd3
`define ALU_SEL_LOAD_STORE  3'd4
`define ALU_SEL_JUMP_BRANCH 3'd5

`define ALU_NOP       8'h00
`define ALU_ADDW      8'h01
`define ALU_SUBW      8'h02
`define ALU_SLT       8'h03
`define ALU_SLTU      8'h04
`define ALU_MULW      8'h05
`define ALU_MULHW     8'h06
`define ALU_MULHWU    8'h07
`define ALU_DIVW      8'h08
`define ALU_MODW      8'h09
`define ALU_DIVWU     8'h0a
`define ALU_MODWU     8'h0b
`define ALU_ADDIW     8'h0c
`define ALU_SLTI      8'h0d
`define ALU_SLTUI     8'h0e
`define ALU_PCADDU12I 8'h0f
`define ALU_NOR       8'h10
`define ALU_AND       8'h11
`define ALU_OR        8'h12
`define ALU_XOR       8'h13
`define ALU_ANDI      8'h14
`define ALU_ORI       8'h15
`define ALU_XORI      8'h16
`define ALU_LU12I     8'h17
`define ALU_SLLW      8'h18
`define ALU_SRLW      8'h19
`define ALU_SRAW      8'h1a
`define ALU_SLLIW     8'h1b
`define ALU_SRLIW     8'h1c
`define ALU_SRAIW     8'h1d
`define ALU_LDB       8'h20
`define ALU_LDH       8'h21
`define ALU_LDW       8'h22
`define ALU_LDBU      8'h23
`define ALU_LDHU      8'h24
`define ALU_STB       8'h25
`define ALU_STH       8'h26
`define ALU_STW       8'h27
`define ALU_BEQ       8'h30
`define ALU_BNE       8'h31
`define ALU_BLT       8'h32
`define ALU_BGE       8'h33
`define ALU_BLTU      8'h34
`define ALU_BGEU      8'h35
`define ALU_B         8'h36
`define ALU_BL        8'h37
`define ALU_JIRL      8'h38
`define ALU_CSRRD     8'h40
`define ALU_CSRWR     8'h41
`define ALU_CSRXCHG   8'h42
`define ALU_ERTN      8'h43
`define ALU_BREAK     8'h44
`define ALU_SYSCALL   8'h45

`define EXCEPTION_NOP 7'h00
`define EXCEPTION_SYS 7'h0b
`define EXCEPTION_BRK 7'h0c
`define EXCEPTION_INE 7'h0d
`define EXCEPTION_IPE 7'h0e

`define CSR_CRMD 14'h0000

`endif

/* common/id_pkg.sv */
package id_pkg;

  typedef logic [31:0] word_t;      // data, pc, inst or imm.
  typedef logic [4:0]  reg_addr_t;  // gpr number.
  typedef logic [13:0] csr_addr_t;  // csr number.
  typedef logic [1:0]  plv_t;       // 0 is kernel.
  typedef logic [7:0]  alu_op_t;
  typedef logic [2:0]  alu_sel_t;
  typedef logic [6:0]  exc_cause_t;

endpackage

/* decode/arith_decoder.sv */
`include "id_config.svh"

module arith_decoder (
  input  id_pkg::word_t     inst,
  output logic              hit,
  output id_pkg::alu_op_t   alu_op,
  output id_pkg::alu_sel_t  alu_sel,
  output logic              reg1_en,
  output logic              reg2_en,
  output id_pkg::reg_addr_t reg1_addr,
  output id_pkg::reg_addr_t reg2_addr,
  output logic              dst_en,
  output id_pkg::reg_addr_t dst_addr,
  output id_pkg::word_t     imm
);
  import id_pkg::*;

  logic [9:0]  op10;
  logic [16:0] op17;
  logic [6:0]  op7;
  word_t       si12_ext;

  assign op10     = inst[31:22];
  assign op17     = inst[31:15];
  assign op7      = inst[31:25];
  assign si12_ext = {{20{inst[21]}}, inst[21:10]};

  always_comb begin
    alu_op = `ALU_NOP;
    case (op10)
      `SLTI_OPCODE:  alu_op = `ALU_SLTI;
      `SLTUI_OPCODE: alu_op = `ALU_SLTUI;
      `ADDIW_OPCODE: alu_op = `ALU_ADDIW;
      `ANDI_OPCODE:  alu_op = `ALU_ANDI;
      `ORI_OPCODE:   alu_op = `ALU_ORI;
      `XORI_OPCODE:  alu_op = `ALU_XORI;
      default: ;
    endcase
    case (op17)
      `ADDW_OPCODE:   alu_op = `ALU_ADDW;
      `SUBW_OPCODE:   alu_op = `ALU_SUBW;
      `SLT_OPCODE:    alu_op = `ALU_SLT;
      `SLTU_OPCODE:   alu_op = `ALU_SLTU;
      `NOR_OPCODE:    alu_op = `ALU_NOR;
      `AND_OPCODE:    alu_op = `ALU_AND;
      `OR_OPCODE:     alu_op = `ALU_OR;
      `XOR_OPCODE:    alu_op = `ALU_XOR;
      `SLLW_OPCODE:   alu_op = `ALU_SLLW;
      `SRLW_OPCODE:   alu_op = `ALU_SRLW;
      `SRAW_OPCODE:   alu_op = `ALU_SRAW;
      `MULW_OPCODE:   alu_op = `ALU_MULW;
      `MULHW_OPCODE:  alu_op = `ALU_MULHW;
      `MULHWU_OPCODE: alu_op = `ALU_MULHWU;
      `DIVW_OPCODE:   alu_op = `ALU_DIVW;
      `MODW_OPCODE:   alu_op = `ALU_MODW;
      `DIVWU_OPCODE:  alu_op = `ALU_DIVWU;
      `MODWU_OPCODE:  alu_op = `ALU_MODWU;
      `SLLIW_OPCODE:  alu_op = `ALU_SLLIW;
      `SRLIW_OPCODE:  alu_op = `ALU_SRLIW;
      `SRAIW_OPCODE:  alu_op = `ALU_SRAIW;
      default: ;
    endcase
    case (op7)
      `LU12I_OPCODE:     alu_op = `ALU_LU12I;
      `PCADDU12I_OPCODE: alu_op = `ALU_PCADDU12I;
      default: ;
    endcase
  end

  assign hit       = (alu_op != `ALU_NOP);
  assign reg1_en   = hit;
  assign reg1_addr = (alu_op == `ALU_LU12I) ? 5'd0 : inst[9:5];  // lu12i adds to r0.
  assign reg2_addr = inst[14:10];
  assign dst_en    = hit;
  assign dst_addr  = inst[4:0];

  always_comb begin
    alu_sel = `ALU_SEL_ARITHMETIC;
    reg2_en = 1'b0;
    imm     = '0;
    case (alu_op)
      `ALU_NOR, `ALU_AND, `ALU_OR, `ALU_XOR: begin
        alu_sel = `ALU_SEL_LOGIC;
        reg2_en = 1'b1;
      end
      `ALU_SLLW, `ALU_SRLW, `ALU_SRAW: begin
        alu_sel = `ALU_SEL_SHIFT;
        reg2_en = 1'b1;
      end
      `ALU_SLTI, `ALU_SLTUI: begin
        alu_sel = `ALU_SEL_SHIFT;  // compares run in the shift unit.
        imm     = si12_ext;
      end
      `ALU_ADDIW: imm = si12_ext;
      `ALU_ANDI, `ALU_ORI, `ALU_XORI: begin
        alu_sel = `ALU_SEL_LOGIC;
        imm     = {20'b0, inst[21:10]};
      end
      `ALU_SLLIW, `ALU_SRLIW, `ALU_SRAIW: begin
        alu_sel = `ALU_SEL_SHIFT;
        imm     = {27'b0, inst[14:10]};
      end
      `ALU_LU12I: begin
        alu_sel = `ALU_SEL_LOGIC;
        imm     = {inst[24:5], 12'b0};
      end
      `ALU_PCADDU12I: imm = {inst[24:5], 12'b0};
      default: reg2_en = 1'b1;  // reg-reg arithmetic.
    endcase
  end

endmodule

/* decode/mem_branch_decoder.sv */
`include "id_config.svh"

module mem_branch_decoder (
  input  id_pkg::word_t     inst,
  output logic              hit,
  output id_pkg::alu_op_t   alu_op,
  output id_pkg::alu_sel_t  alu_sel,
  output logic              reg1_en,
  output logic              reg2_en,
  output id_pkg::reg_addr_t reg1_addr,
  output id_pkg::reg_addr_t reg2_addr,
  output logic              dst_en,
  output id_pkg::reg_addr_t dst_addr,
  output id_pkg::word_t     imm
);
  import id_pkg::*;

  word_t si12_ext;
  word_t offs16_ext;
  word_t offs26_ext;

  assign si12_ext   = {{20{inst[21]}}, inst[21:10]};
  assign offs16_ext = {{14{inst[25]}}, inst[25:10], 2'b00};
  assign offs26_ext = {{4{inst[9]}}, inst[9:0], inst[25:10], 2'b00};

  always_comb begin
    alu_op = `ALU_NOP;
    case (inst[31:22])
      `LDB_OPCODE:  alu_op = `ALU_LDB;
      `LDH_OPCODE:  alu_op = `ALU_LDH;
      `LDW_OPCODE:  alu_op = `ALU_LDW;
      `LDBU_OPCODE: alu_op = `ALU_LDBU;
      `LDHU_OPCODE: alu_op = `ALU_LDHU;
      `STB_OPCODE:  alu_op = `ALU_STB;
      `STH_OPCODE:  alu_op = `ALU_STH;
      `STW_OPCODE:  alu_op = `ALU_STW;
      default: ;
    endcase
    case (inst[31:26])
      `JIRL_OPCODE: alu_op = `ALU_JIRL;
      `B_OPCODE:    alu_op = `ALU_B;
      `BL_OPCODE:   alu_op = `ALU_BL;
      `BEQ_OPCODE:  alu_op = `ALU_BEQ;
      `BNE_OPCODE:  alu_op = `ALU_BNE;
      `BLT_OPCODE:  alu_op = `ALU_BLT;
      `BGE_OPCODE:  alu_op = `ALU_BGE;
      `BLTU_OPCODE: alu_op = `ALU_BLTU;
      `BGEU_OPCODE: alu_op = `ALU_BGEU;
      default: ;
    endcase
  end

  assign hit       = (alu_op != `ALU_NOP);
  assign reg1_addr = inst[9:5];
  assign reg2_addr = inst[4:0];  // store data and branch compare use rd.

  always_comb begin
    alu_sel  = `ALU_SEL_JUMP_BRANCH;
    reg1_en  = 1'b1;
    reg2_en  = 1'b0;
    dst_en   = 1'b0;
    dst_addr = inst[4:0];
    imm      = offs16_ext;
    case (alu_op)
      `ALU_LDB, `ALU_LDH, `ALU_LDW, `ALU_LDBU, `ALU_LDHU: begin
        alu_sel = `ALU_SEL_LOAD_STORE;
        dst_en  = 1'b1;
        imm     = si12_ext;
      end
      `ALU_STB, `ALU_STH, `ALU_STW: begin
        alu_sel = `ALU_SEL_LOAD_STORE;
        reg2_en = 1'b1;
        imm     = si12_ext;
      end
      `ALU_BEQ, `ALU_BNE, `ALU_BLT, `ALU_BGE, `ALU_BLTU, `ALU_BGEU: reg2_en = 1'b1;
      `ALU_B: begin
        reg1_en = 1'b0;
        imm     = offs26_ext;
      end
      `ALU_BL: begin
        reg1_en  = 1'b0;
        dst_en   = 1'b1;
        dst_addr = 5'd1;  // link register.
        imm      = offs26_ext;
      end
      `ALU_JIRL: dst_en = 1'b1;
      default: ;
    endcase
  end

endmodule

/* decode/priv_decoder.sv */
`include "id_config.svh"

module priv_decoder (
  input  id_pkg::word_t      inst,
  input  id_pkg::plv_t       plv,
  output logic               hit,
  output id_pkg::alu_op_t    alu_op,
  output logic               reg1_en,
  output logic               reg2_en,
  output id_pkg::reg_addr_t  reg1_addr,
  output id_pkg::reg_addr_t  reg2_addr,
  output logic               dst_en,
  output id_pkg::reg_addr_t  dst_addr,
  output logic               csr_read,
  output logic               csr_write,
  output id_pkg::csr_addr_t  csr_num,
  output logic               exc,
  output id_pkg::exc_cause_t exc_cause
);
  import id_pkg::*;

  reg_addr_t rj;
  logic      is_csr;
  logic      need_kernel;

  assign rj      = inst[9:5];
  assign is_csr  = (inst[31:24] == `CSR_OPCODE);
  assign csr_num = inst[23:10];

  always_comb begin
    alu_op = `ALU_NOP;
    if (is_csr) begin
      if (rj == 5'd0) begin
        alu_op = `ALU_CSRRD;
      end else if (rj == 5'd1) begin
        alu_op = `ALU_CSRWR;
      end else begin
        alu_op = `ALU_CSRXCHG;  // rj holds the write mask.
      end
    end else if (inst[31:15] == `BREAK_OPCODE) begin
      alu_op = `ALU_BREAK;
    end else if (inst[31:15] == `SYSCALL_OPCODE) begin
      alu_op = `ALU_SYSCALL;
    end else if (inst[31:10] == `ERTN_OPCODE) begin
      alu_op = `ALU_ERTN;
    end
  end

  assign hit         = (alu_op != `ALU_NOP);
  assign need_kernel = is_csr || (alu_op == `ALU_ERTN);
  assign csr_read    = is_csr;
  assign csr_write   = is_csr && (rj != 5'd0);
  assign reg1_en     = csr_write;  // new value comes from rd.
  assign reg1_addr   = inst[4:0];
  assign reg2_en     = (alu_op == `ALU_CSRXCHG);
  assign reg2_addr   = rj;
  assign dst_en      = is_csr;
  assign dst_addr    = inst[4:0];

  always_comb begin
    exc       = 1'b1;
    exc_cause = `EXCEPTION_NOP;
    if (need_kernel && (plv != 2'd0)) begin
      exc_cause = `EXCEPTION_IPE;
    end else if (alu_op == `ALU_BREAK) begin
      exc_cause = `EXCEPTION_BRK;
    end else if (alu_op == `ALU_SYSCALL) begin
      exc_cause = `EXCEPTION_SYS;
    end else begin
      exc = 1'b0;
    end
  end

endmodule

/* id_stage.f */
+incdir+common
common/id_pkg.sv
decode/arith_decoder.sv
decode/mem_branch_decoder.sv
decode/priv_decoder.sv
logic/plv_tracker.sv
logic/dispatch_reg.sv
logic/id_stage.sv
verif/id_stage_sva.sv
verif/id_stage_tb.sv

/* logic/dispatch_reg.sv */
`include "id_config.svh"

module dispatch_reg (
  input  logic               clk,
  input  logic               rst,
  input  logic               in_valid,
  input  id_pkg::word_t      pc,
  input  id_pkg::word_t      inst,
  input  logic               arith_hit, mem_hit, priv_hit,
  input  id_pkg::alu_op_t    arith_alu_op, mem_alu_op, priv_alu_op,
  input  id_pkg::alu_sel_t   arith_alu_sel, mem_alu_sel,
  input  logic               arith_reg1_en, arith_reg2_en, arith_dst_en,
  input  logic               mem_reg1_en, mem_reg2_en, mem_dst_en,
  input  logic               priv_reg1_en, priv_reg2_en, priv_dst_en,
  input  id_pkg::reg_addr_t  arith_reg1_addr, arith_reg2_addr, arith_dst_addr,
  input  id_pkg::reg_addr_t  mem_reg1_addr, mem_reg2_addr, mem_dst_addr,
  input  id_pkg::reg_addr_t  priv_reg1_addr, priv_reg2_addr, priv_dst_addr,
  input  id_pkg::word_t      arith_imm, mem_imm,
  input  logic               priv_csr_read, priv_csr_write, priv_exc,
  input  id_pkg::csr_addr_t  priv_csr_num,
  input  id_pkg::exc_cause_t priv_exc_cause,
  output logic               out_valid,
  output id_pkg::word_t      out_pc,
  output id_pkg::alu_op_t    alu_op,
  output id_pkg::alu_sel_t   alu_sel,
  output logic               reg1_en,
  output id_pkg::reg_addr_t  reg1_addr,
  output logic               reg2_en,
  output id_pkg::reg_addr_t  reg2_addr,
  output logic               dst_en,
  output id_pkg::reg_addr_t  dst_addr,
  output id_pkg::word_t      imm,
  output logic               csr_read,
  output logic               csr_write,
  output id_pkg::csr_addr_t  csr_num,
  output logic               exc,
  output id_pkg::exc_cause_t exc_cause
);
  import id_pkg::*;

  logic       any_hit;
  logic       ine;
  alu_op_t    d_alu_op;
  alu_sel_t   d_alu_sel;
  logic       d_reg1_en, d_reg2_en, d_dst_en;
  reg_addr_t  d_reg1_addr, d_reg2_addr, d_dst_addr;
  word_t      d_imm;
  exc_cause_t d_exc_cause;

  assign any_hit = arith_hit | mem_hit | priv_hit;
  assign ine     = !any_hit && (inst != '0);  // all-zero word is a silent nop.

  // decoder groups never hit together.
  assign d_alu_op    = arith_hit ? arith_alu_op : mem_hit ? mem_alu_op :
                       priv_hit ? priv_alu_op : `ALU_NOP;
  assign d_alu_sel   = arith_hit ? arith_alu_sel : mem_hit ? mem_alu_sel : `ALU_SEL_NOP;
  assign d_reg1_en   = (arith_hit & arith_reg1_en) | (mem_hit & mem_reg1_en) |
                       (priv_hit & priv_reg1_en);
  assign d_reg2_en   = (arith_hit & arith_reg2_en) | (mem_hit & mem_reg2_en) |
                       (priv_hit & priv_reg2_en);
  assign d_dst_en    = (arith_hit & arith_dst_en) | (mem_hit & mem_dst_en) |
                       (priv_hit & priv_dst_en);
  assign d_reg1_addr = arith_hit ? arith_reg1_addr : mem_hit ? mem_reg1_addr :
                       priv_hit ? priv_reg1_addr : 5'd0;
  assign d_reg2_addr = arith_hit ? arith_reg2_addr : mem_hit ? mem_reg2_addr :
                       priv_hit ? priv_reg2_addr : 5'd0;
  assign d_dst_addr  = arith_hit ? arith_dst_addr : mem_hit ? mem_dst_addr :
                       priv_hit ? priv_dst_addr : 5'd0;
  assign d_imm       = arith_hit ? arith_imm : mem_hit ? mem_imm : '0;
  assign d_exc_cause = priv_hit ? priv_exc_cause : ine ? `EXCEPTION_INE : `EXCEPTION_NOP;

  always_ff @(posedge clk) begin
    if (rst) begin
      out_valid <= 1'b0;
      exc       <= 1'b0;
      exc_cause <= `EXCEPTION_NOP;
    end else begin
      out_valid <= in_valid;
      if (in_valid) begin
        exc       <= (priv_hit & priv_exc) | ine;
        exc_cause <= d_exc_cause;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (in_valid) begin
      out_pc    <= pc;
      alu_op    <= d_alu_op;
      alu_sel   <= d_alu_sel;
      reg1_en   <= d_reg1_en;
      reg1_addr <= d_reg1_addr;
      reg2_en   <= d_reg2_en;
      reg2_addr <= d_reg2_addr;
      dst_en    <= d_dst_en;
      dst_addr  <= d_dst_addr;
      imm       <= d_imm;
      csr_read  <= priv_hit & priv_csr_read;
      csr_write <= priv_hit & priv_csr_write;
      csr_num   <= priv_csr_num;
    end
  end

endmodule

/* logic/id_stage.sv */
module id_stage (
  input  logic               clk,
  input  logic               rst,
  input  logic               in_valid,
  input  id_pkg::word_t      pc,
  input  id_pkg::word_t      inst,
  input  logic               csr_wr_en,
  input  id_pkg::csr_addr_t  csr_wr_addr,
  input  id_pkg::word_t      csr_wr_data,
  output logic               out_valid,
  output id_pkg::word_t      out_pc,
  output id_pkg::alu_op_t    alu_op,
  output id_pkg::alu_sel_t   alu_sel,
  output logic               reg1_en,
  output id_pkg::reg_addr_t  reg1_addr,
  output logic               reg2_en,
  output id_pkg::reg_addr_t  reg2_addr,
  output logic               dst_en,
  output id_pkg::reg_addr_t  dst_addr,
  output id_pkg::word_t      imm,
  output logic               csr_read,
  output logic               csr_write,
  output id_pkg::csr_addr_t  csr_num,
  output logic               exc,
  output id_pkg::exc_cause_t exc_cause
);
  import id_pkg::*;

  logic       arith_hit, mem_hit, priv_hit;
  logic       arith_reg1_en, arith_reg2_en, arith_dst_en;
  logic       mem_reg1_en, mem_reg2_en, mem_dst_en;
  logic       priv_reg1_en, priv_reg2_en, priv_dst_en;
  logic       priv_csr_read, priv_csr_write, priv_exc;
  alu_op_t    arith_alu_op, mem_alu_op, priv_alu_op;
  alu_sel_t   arith_alu_sel, mem_alu_sel;
  reg_addr_t  arith_reg1_addr, arith_reg2_addr, arith_dst_addr;
  reg_addr_t  mem_reg1_addr, mem_reg2_addr, mem_dst_addr;
  reg_addr_t  priv_reg1_addr, priv_reg2_addr, priv_dst_addr;
  word_t      arith_imm, mem_imm;
  csr_addr_t  priv_csr_num;
  exc_cause_t priv_exc_cause;
  plv_t       plv_now;

  arith_decoder u_arith (
    .inst      (inst),
    .hit       (arith_hit),
    .alu_op    (arith_alu_op),
    .alu_sel   (arith_alu_sel),
    .reg1_en   (arith_reg1_en),
    .reg2_en   (arith_reg2_en),
    .reg1_addr (arith_reg1_addr),
    .reg2_addr (arith_reg2_addr),
    .dst_en    (arith_dst_en),
    .dst_addr  (arith_dst_addr),
    .imm       (arith_imm)
  );

  mem_branch_decoder u_mem (
    .inst      (inst),
    .hit       (mem_hit),
    .alu_op    (mem_alu_op),
    .alu_sel   (mem_alu_sel),
    .reg1_en   (mem_reg1_en),
    .reg2_en   (mem_reg2_en),
    .reg1_addr (mem_reg1_addr),
    .reg2_addr (mem_reg2_addr),
    .dst_en    (mem_dst_en),
    .dst_addr  (mem_dst_addr),
    .imm       (mem_imm)
  );

  priv_decoder u_priv (
    .inst      (inst),
    .plv       (plv_now),  // includes a same-cycle crmd write.
    .hit       (priv_hit),
    .alu_op    (priv_alu_op),
    .reg1_en   (priv_reg1_en),
    .reg2_en   (priv_reg2_en),
    .reg1_addr (priv_reg1_addr),
    .reg2_addr (priv_reg2_addr),
    .dst_en    (priv_dst_en),
    .dst_addr  (priv_dst_addr),
    .csr_read  (priv_csr_read),
    .csr_write (priv_csr_write),
    .csr_num   (priv_csr_num),
    .exc       (priv_exc),
    .exc_cause (priv_exc_cause)
  );

  plv_tracker u_plv (.*);

  dispatch_reg u_dispatch (.*);

endmodule

/* logic/plv_tracker.sv */
`include "id_config.svh"

module plv_tracker (
  input  logic              clk,
  input  logic              rst,
  input  logic              csr_wr_en,
  input  id_pkg::csr_addr_t csr_wr_addr,
  input  id_pkg::word_t     csr_wr_data,
  output id_pkg::plv_t      plv_now
);
  import id_pkg::*;

  plv_t plv_q;
  logic crmd_wr;

  assign crmd_wr = csr_wr_en && (csr_wr_addr == `CSR_CRMD);
  assign plv_now = crmd_wr ? csr_wr_data[1:0] : plv_q;  // bypass the pending write.

  always_ff @(posedge clk) begin
    if (rst) begin
      plv_q <= '0;
    end else if (crmd_wr) begin
      plv_q <= csr_wr_data[1:0];
    end
  end

endmodule

/* run_sim.sh */
#!/bin/sh
set -e

verilator --binary --timing --assert -f id_stage.f --top-module id_stage_tb -o id_stage_sim

./obj_dir/id_stage_sim > sim.log 2>&1 || true
cat sim.log

if grep -q '^\*\* PASS \*\*$' sim.log; then
  echo "simulation passed"
  exit 0
else
  echo "simulation failed"
  exit 1
fi

/* verif/id_stage_input.txt */
# name csr_wr_en csr_wr_data pc inst | alu_op alu_sel dst_en dst_addr imm csr_read csr_write exc exc_cause
# all values hex; csr writes go to CRMD
add_w      0 00000000 1c000000 00100823 01 3 1 03 00000000 0 0 0 00
sub_w      0 00000000 1c000004 001118a4 02 3 1 04 00000000 0 0 0 00
and        0 00000000 1c000008 0014a507 11 1 1 07 00000000 0 0 0 00
sra_w      0 00000000 1c00000c 0018316a 1a 2 1 0a 00000000 0 0 0 00
mul_w      0 00000000 1c000010 001c3dcd 05 3 1 0d 00000000 0 0 0 00
div_wu     0 00000000 1c000014 00210c41 0a 3 1 01 00000000 0 0 0 00
addi_w     0 00000000 1c000018 02bffcc5 0c 3 1 05 ffffffff 0 0 0 00
slti       0 00000000 1c00001c 021ffc62 0d 2 1 02 000007ff 0 0 0 00
sltui      0 00000000 1c000020 026000a4 0e 2 1 04 fffff800 0 0 0 00
ori        0 00000000 1c000024 03aaf0e6 15 1 1 06 00000abc 0 0 0 00
slli_w     0 00000000 1c000028 0040fd28 1b 2 1 08 0000001f 0 0 0 00
srai_w     0 00000000 1c00002c 00489441 1d 2 1 01 00000005 0 0 0 00
lu12i_w    0 00000000 1c000030 142468a3 17 1 1 03 12345000 0 0 0 00
pcaddu12i  0 00000000 1c000034 1d000004 0f 3 1 04 80000000 0 0 0 00
ld_w       0 00000000 1c000038 28bff0c5 22 4 1 05 fffffffc 0 0 0 00
ld_bu      0 00000000 1c00003c 2a004107 23 4 1 07 00000010 0 0 0 00
st_h       0 00000000 1c000040 295ff949 26 4 0 00 000007fe 0 0 0 00
beq        0 00000000 1c000044 5bfff822 30 5 0 00 fffffff8 0 0 0 00
bgeu       0 00000000 1c000048 6c004064 35 5 0 00 00000040 0 0 0 00
bl         0 00000000 1c00004c 54040000 37 5 1 01 00000400 0 0 0 00
jirl       0 00000000 1c000050 4c0004a6 38 5 1 06 00000004 0 0 0 00
unknown    0 00000000 1c000054 ffffffff 00 0 0 00 00000000 0 0 1 0d
zero_word  0 00000000 1c000058 00000000 00 0 0 00 00000000 0 0 0 00
csrrd_k    0 00000000 1c00005c 04001401 40 0 1 01 00000000 1 0 0 00
csrwr_k    0 00000000 1c000060 04001822 41 0 1 02 00000000 1 1 0 00
csrxchg_k  0 00000000 1c000064 04001c83 42 0 1 03 00000000 1 1 0 00
break      0 00000000 1c000068 002a0000 44 0 0 00 00000000 0 0 1 0c
syscall    0 00000000 1c00006c 002b0000 45 0 0 00 00000000 0 0 1 0b
ertn_k     0 00000000 1c000070 06483800 43 0 0 00 00000000 0 0 0 00
csrrd_fwd  1 00000003 1c000074 04000001 40 0 1 01 00000000 1 0 1 0e
csrwr_u    0 00000000 1c000078 04001822 41 0 1 02 00000000 1 1 1 0e
ertn_u     0 00000000 1c00007c 06483800 43 0 0 00 00000000 0 0 1 0e
break_u    0 00000000 1c000080 002a0000 44 0 0 00 00000000 0 0 1 0c
csrxchg_fw 1 00000000 1c000084 04001c83 42 0 1 03 00000000 1 1 0 00
csrrd_back 0 00000000 1c000088 04001401 40 0 1 01 00000000 1 0 0 00

/* verif/id_stage_sva.sv */
`include "id_config.svh"

module id_stage_sva (
  input logic               clk,
  input logic               rst,
  input logic               out_valid,
  input logic               exc,
  input id_pkg::exc_cause_t exc_cause
);

  // slot is empty right after a reset edge.
  assert property (@(posedge clk) rst |=> !out_valid)
    else $error("out_valid high in the cycle after reset");

  assert property (@(posedge clk) disable iff (rst) exc |-> (exc_cause != `EXCEPTION_NOP))
    else $error("exc raised with a zero exc_cause");

endmodule

bind id_stage id_stage_sva u_sva (
  .clk       (clk),
  .rst       (rst),
  .out_valid (out_valid),
  .exc       (exc),
  .exc_cause (exc_cause)
);

/* verif/id_stage_tb.sv */
`include "id_config.svh"

module id_stage_tb;
  import id_pkg::*;

  localparam int MAX_VECS = 64;

  logic       clk;
  logic       rst;
  logic       in_valid;
  word_t      pc;
  word_t      inst;
  logic       csr_wr_en;
  csr_addr_t  csr_wr_addr;
  word_t      csr_wr_data;
  logic       out_valid;
  word_t      out_pc;
  alu_op_t    alu_op;
  alu_sel_t   alu_sel;
  logic       reg1_en, reg2_en, dst_en;
  reg_addr_t  reg1_addr, reg2_addr, dst_addr;
  word_t      imm;
  logic       csr_read, csr_write, exc;
  csr_addr_t  csr_num;
  exc_cause_t exc_cause;

  string      v_name      [MAX_VECS];
  logic       v_wr_en     [MAX_VECS];
  word_t      v_wr_data   [MAX_VECS];
  word_t      v_pc        [MAX_VECS];
  word_t      v_inst      [MAX_VECS];
  alu_op_t    v_alu_op    [MAX_VECS];
  alu_sel_t   v_alu_sel   [MAX_VECS];
  logic       v_dst_en    [MAX_VECS];
  reg_addr_t  v_dst_addr  [MAX_VECS];
  word_t      v_imm       [MAX_VECS];
  logic       v_csr_read  [MAX_VECS];
  logic       v_csr_write [MAX_VECS];
  logic       v_exc       [MAX_VECS];
  exc_cause_t v_exc_cause [MAX_VECS];

  int   n_vecs;
  int   n_errors;
  int   n_checks;
  logic loaded;

  id_stage uut (
    .clk         (clk),
    .rst         (rst),
    .in_valid    (in_valid),
    .pc          (pc),
    .inst        (inst),
    .csr_wr_en   (csr_wr_en),
    .csr_wr_addr (csr_wr_addr),
    .csr_wr_data (csr_wr_data),
    .out_valid   (out_valid),
    .out_pc      (out_pc),
    .alu_op      (alu_op),
    .alu_sel     (alu_sel),
    .reg1_en     (reg1_en),
    .reg1_addr   (reg1_addr),
    .reg2_en     (reg2_en),
    .reg2_addr   (reg2_addr),
    .dst_en      (dst_en),
    .dst_addr    (dst_addr),
    .imm         (imm),
    .csr_read    (csr_read),
    .csr_write   (csr_write),
    .csr_num     (csr_num),
    .exc         (exc),
    .exc_cause   (exc_cause)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  task automatic load_vectors();
    int         fd;
    int         rc;
    string      line;
    string      name;
    logic       en, crd, cwr, ex;
    word_t      wdata, vpc, vinst, vimm;
    alu_op_t    op;
    alu_sel_t   sel;
    logic       den;
    reg_addr_t  dst;
    exc_cause_t cause;
    fd = $fopen("verif/id_stage_input.txt", "r");
    if (fd == 0) begin
      $display("error: cannot open verif/id_stage_input.txt");
      n_errors++;
      return;
    end
    while (!$feof(fd) && n_vecs < MAX_VECS) begin
      line = "";
      rc = $fgets(line, fd);
      rc = $sscanf(line, "%s %h %h %h %h %h %h %h %h %h %h %h %h %h", name, en, wdata, vpc,
                   vinst, op, sel, den, dst, vimm, crd, cwr, ex, cause);
      if (rc == 14) begin  // comment and blank lines fall through.
        v_name[n_vecs]      = name;
        v_wr_en[n_vecs]     = en;
        v_wr_data[n_vecs]   = wdata;
        v_pc[n_vecs]        = vpc;
        v_inst[n_vecs]      = vinst;
        v_alu_op[n_vecs]    = op;
        v_alu_sel[n_vecs]   = sel;
        v_dst_en[n_vecs]    = den;
        v_dst_addr[n_vecs]  = dst;
        v_imm[n_vecs]       = vimm;
        v_csr_read[n_vecs]  = crd;
        v_csr_write[n_vecs] = cwr;
        v_exc[n_vecs]       = ex;
        v_exc_cause[n_vecs] = cause;
        n_vecs++;
      end
    end
    $fclose(fd);
  endtask

  task automatic compare_field(string test, string field, logic [31:0] expected,
                               logic [31:0] actual);
    n_checks++;
    if (actual !== expected) begin
      n_errors++;
      $display("FAIL %s %s expected %h actual %h", test, field, expected, actual);
    end
  endtask

  task automatic drive_vector(int i);
    in_valid    = 1'b1;
    csr_wr_en   = v_wr_en[i];
    csr_wr_data = v_wr_data[i];
    pc          = v_pc[i];
    inst        = v_inst[i];
  endtask

  task automatic check_operands(int i);
    reg_addr_t rd;
    reg_addr_t rj;
    logic      en1, en2;
    reg_addr_t addr1, addr2;
    rd    = v_inst[i][4:0];
    rj    = v_inst[i][9:5];
    en1   = 1'b0;
    en2   = 1'b0;
    addr1 = rj;
    addr2 = rd;
    case (v_alu_op[i])
      `ALU_ADDW, `ALU_SUBW, `ALU_SLT, `ALU_SLTU, `ALU_NOR, `ALU_AND, `ALU_OR, `ALU_XOR,
      `ALU_SLLW, `ALU_SRLW, `ALU_SRAW, `ALU_MULW, `ALU_MULHW, `ALU_MULHWU,
      `ALU_DIVW, `ALU_MODW, `ALU_DIVWU, `ALU_MODWU: begin
        en1   = 1'b1;
        en2   = 1'b1;
        addr2 = v_inst[i][14:10];
      end
      `ALU_ADDIW, `ALU_SLTI, `ALU_SLTUI, `ALU_ANDI, `ALU_ORI, `ALU_XORI, `ALU_SLLIW,
      `ALU_SRLIW, `ALU_SRAIW, `ALU_LDB, `ALU_LDH, `ALU_LDW, `ALU_LDBU, `ALU_LDHU,
      `ALU_JIRL: en1 = 1'b1;
      `ALU_LU12I: begin
        en1   = 1'b1;
        addr1 = 5'd0;
      end
      `ALU_STB, `ALU_STH, `ALU_STW, `ALU_BEQ, `ALU_BNE, `ALU_BLT, `ALU_BGE, `ALU_BLTU,
      `ALU_BGEU: begin
        en1 = 1'b1;
        en2 = 1'b1;
      end
      `ALU_CSRWR: begin
        en1   = 1'b1;
        addr1 = rd;
      end
      `ALU_CSRXCHG: begin
        en1   = 1'b1;
        en2   = 1'b1;
        addr1 = rd;
        addr2 = rj;
      end
      default: ;
    endcase
    if (v_alu_op[i] != `ALU_PCADDU12I) begin  // reg1 of pcaddu12i is left open.
      compare_field(v_name[i], "reg1_en", 32'(en1), 32'(reg1_en));
      if (en1) begin
        compare_field(v_name[i], "reg1_addr", 32'(addr1), 32'(reg1_addr));
      end
    end
    compare_field(v_name[i], "reg2_en", 32'(en2), 32'(reg2_en));
    if (en2) begin
      compare_field(v_name[i], "reg2_addr", 32'(addr2), 32'(reg2_addr));
    end
  endtask

  task automatic check_vector(int i);
    n_checks++;
    if (out_valid !== 1'b1) begin
      n_errors++;
      $display("out_valid stayed low one cycle after %s was issued", v_name[i]);
    end
    compare_field(v_name[i], "out_pc", v_pc[i], out_pc);
    compare_field(v_name[i], "alu_op", 32'(v_alu_op[i]), 32'(alu_op));
    compare_field(v_name[i], "alu_sel", 32'(v_alu_sel[i]), 32'(alu_sel));
    compare_field(v_name[i], "dst_en", 32'(v_dst_en[i]), 32'(dst_en));
    if (v_dst_en[i]) begin  // dst_addr is free when nothing is written.
      compare_field(v_name[i], "dst_addr", 32'(v_dst_addr[i]), 32'(dst_addr));
    end
    compare_field(v_name[i], "imm", v_imm[i], imm);
    compare_field(v_name[i], "csr_read", 32'(v_csr_read[i]), 32'(csr_read));
    compare_field(v_name[i], "csr_write", 32'(v_csr_write[i]), 32'(csr_write));
    if (v_csr_read[i]) begin  // csr number field of the instruction.
      compare_field(v_name[i], "csr_num", 32'(v_inst[i][23:10]), 32'(csr_num));
    end
    compare_field(v_name[i], "exc", 32'(v_exc[i]), 32'(exc));
    compare_field(v_name[i], "exc_cause", 32'(v_exc_cause[i]), 32'(exc_cause));
    check_operands(i);
  endtask

  initial begin
    rst         = 1'b1;
    in_valid    = 1'b0;
    pc          = '0;
    inst        = '0;
    csr_wr_en   = 1'b0;
    csr_wr_addr = `CSR_CRMD;
    csr_wr_data = '0;
    n_vecs      = 0;
    n_errors    = 0;
    n_checks    = 0;
    loaded      = 1'b0;
    load_vectors();
    if (n_vecs == 0) begin
      $display("error: no test vectors were read");
      n_errors++;
    end
    loaded = 1'b1;
    repeat (5) @(negedge clk);
    rst = 1'b0;
    n_checks++;
    if (out_valid !== 1'b0 || exc !== 1'b0) begin
      n_errors++;
      $display("out_valid or exc is not low after reset");
    end
    for (int i = 0; i < n_vecs; i++) begin
      drive_vector(i);
      @(negedge clk);
      check_vector(i);
    end
    in_valid  = 1'b0;
    csr_wr_en = 1'b0;
    pc        = '0;
    inst      = '1;
    @(negedge clk);
    n_checks++;
    if (out_valid !== 1'b0) begin
      n_errors++;
      $display("out_valid high in a cycle with no instruction issued");
    end
    if (n_vecs > 0) begin  // idle slot keeps the last decode.
      compare_field("idle_hold", "out_pc", v_pc[n_vecs-1], out_pc);
      compare_field("idle_hold", "alu_op", 32'(v_alu_op[n_vecs-1]), 32'(alu_op));
      compare_field("idle_hold", "exc", 32'(v_exc[n_vecs-1]), 32'(exc));
    end
    $display("checks %0d, errors %0d", n_checks, n_errors);
    if (n_errors == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

  initial begin
    wait (loaded);
    #((n_vecs + 20) * 100);
    $display("timeout: the run did not finish within %0d cycles", n_vecs + 20);
    $display("** FAIL **");
    $finish;
  end

endmodule
